// ==== logic/dtl_address_isolator.sv ====
`timescale 1ns/1ps
`include "gm_defines.svh"
`default_nettype none

module dtl_address_isolator (
	input logic clk,
	input logic rst,
	dtl_if.slave up,
	dtl_if.master down
);

	localparam logic [1:0] ST_PASS = 2'd0;
	localparam logic [1:0] ST_SINK_WR = 2'd1;
	localparam logic [1:0] ST_SRC_RD = 2'd2;

	logic [1:0] state;
	gm_pkg::block_t count;
	logic out_of_range;
	logic own;

	assign out_of_range = (up.addr.flat > `GM_ADDR_WIDTH'(`GM_RANGE_HIGH));
	assign own = (state != ST_PASS);

	// ----------------------------------------
	// command, in-range commands go straight through
	assign down.cmd_valid = up.cmd_valid && !out_of_range && !own;
	assign down.cmd_read = up.cmd_read;
	assign down.addr = up.addr;
	assign down.block_size = up.block_size;
	assign up.cmd_accept = own ? 1'b0 : (out_of_range ? up.cmd_valid : down.cmd_accept);

	// write beats are swallowed while the transfer is handled here
	assign down.wr_valid = up.wr_valid && !own;
	assign down.wr_last = up.wr_last;
	assign down.wr_mask = up.wr_mask;
	assign down.wr_data = up.wr_data;
	assign up.wr_accept = (state == ST_SINK_WR) || (!own && down.wr_accept);

	// reads outside the memory return zero
	assign down.rd_accept = up.rd_accept && !own;
	assign up.rd_valid = (state == ST_SRC_RD) || (!own && down.rd_valid);
	assign up.rd_last = own ? ((state == ST_SRC_RD) && (count == '0)) : down.rd_last;
	assign up.rd_data = own ? '0 : down.rd_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_PASS;
		end
		else
		begin
			case (state)
				ST_PASS:
				begin
					if (up.cmd_valid && out_of_range)
						state <= up.cmd_read ? ST_SRC_RD : ST_SINK_WR;
				end
				ST_SINK_WR:
				begin
					if (up.wr_valid && (count == '0))
						state <= ST_PASS;
				end
				ST_SRC_RD:
				begin
					if (up.rd_accept && (count == '0))
						state <= ST_PASS;
				end
				default:
					state <= ST_PASS;
			endcase
		end
	end

	// beats left in the local transfer
	always_ff @(posedge clk)
	begin
		if (state == ST_PASS)
			count <= up.block_size;
		else if ((state == ST_SINK_WR && up.wr_valid) || (state == ST_SRC_RD && up.rd_accept))
			count <= count - 1'b1;
	end

endmodule

`default_nettype wire

// ==== logic/dtl_arbiter.sv ====
`timescale 1ns/1ps
`include "gm_defines.svh"
`default_nettype none

module dtl_arbiter (
	input logic clk,
	input logic rst,
	dtl_if.slave host,
	dtl_if.slave core,
	dtl_if.master out
);

	localparam int SEL_W = $clog2(`GM_NUM_PORTS);

	logic [`GM_NUM_PORTS-1:0] req;
	logic [SEL_W-1:0] pick;
	logic [SEL_W-1:0] grant;
	logic [SEL_W-1:0] sel;
	logic busy;
	logic use_core;
	logic cmd_done;
	logic data_done;

	assign req = {core.cmd_valid, host.cmd_valid};

	// lowest index wins, so the host has priority
	always_comb
	begin
		pick = '0;
		for (int i = `GM_NUM_PORTS - 1; i >= 0; i--)
		begin
			if (req[i])
				pick = SEL_W'(i);
		end
	end

	assign sel = busy ? grant : pick;
	assign use_core = (sel == SEL_W'(1));

	// ----------------------------------------
	// towards the memory
	assign out.cmd_valid = !busy && (req != '0);
	assign out.cmd_read = use_core ? core.cmd_read : host.cmd_read;
	assign out.addr = use_core ? core.addr : host.addr;
	assign out.block_size = use_core ? core.block_size : host.block_size;
	assign out.wr_valid = busy && (use_core ? core.wr_valid : host.wr_valid);
	assign out.wr_last = use_core ? core.wr_last : host.wr_last;
	assign out.wr_mask = use_core ? core.wr_mask : host.wr_mask;
	assign out.wr_data = use_core ? core.wr_data : host.wr_data;
	assign out.rd_accept = busy && (use_core ? core.rd_accept : host.rd_accept);

	// ----------------------------------------
	// back to the ports, only the granted one sees handshakes
	assign host.cmd_accept = !busy && !use_core && host.cmd_valid && out.cmd_accept;
	assign host.wr_accept = busy && !use_core && out.wr_accept;
	assign host.rd_valid = busy && !use_core && out.rd_valid;
	assign host.rd_last = busy && !use_core && out.rd_last;
	assign host.rd_data = out.rd_data;

	assign core.cmd_accept = !busy && use_core && core.cmd_valid && out.cmd_accept;
	assign core.wr_accept = busy && use_core && out.wr_accept;
	assign core.rd_valid = busy && use_core && out.rd_valid;
	assign core.rd_last = busy && use_core && out.rd_last;
	assign core.rd_data = out.rd_data;

	assign cmd_done = out.cmd_valid && out.cmd_accept;
	assign data_done = (out.wr_valid && out.wr_accept && out.wr_last) ||
		(out.rd_valid && out.rd_accept && out.rd_last);

	// grant held from command until the last data beat
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			grant <= '0;
		end
		else if (!busy)
		begin
			if (cmd_done)
			begin
				busy <= 1'b1;
				grant <= pick;
			end
		end
		else if (data_done)
		begin
			busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/dtl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dtl_if;

	// ----------------------------------------
	// command channel
	logic cmd_valid;
	logic cmd_accept;
	logic cmd_read;
	gm_pkg::dtl_addr_u addr;
	gm_pkg::block_t block_size;

	// ----------------------------------------
	// write channel
	logic wr_valid;
	logic wr_accept;
	logic wr_last;
	gm_pkg::strb_t wr_mask;
	gm_pkg::data_t wr_data;

	// ----------------------------------------
	// read channel
	logic rd_valid;
	logic rd_accept;
	logic rd_last;
	gm_pkg::data_t rd_data;

	modport master (
		output cmd_valid, cmd_read, addr, block_size,
		output wr_valid, wr_last, wr_mask, wr_data,
		output rd_accept,
		input cmd_accept, wr_accept, rd_valid, rd_last, rd_data
	);

	modport slave (
		input cmd_valid, cmd_read, addr, block_size,
		input wr_valid, wr_last, wr_mask, wr_data,
		input rd_accept,
		output cmd_accept, wr_accept, rd_valid, rd_last, rd_data
	);

endinterface

`default_nettype wire

// ==== logic/dtl_sram_controller.sv ====
`timescale 1ns/1ps
`include "gm_defines.svh"
`default_nettype none

module dtl_sram_controller (
	input logic clk,
	input logic rst,
	dtl_if.slave bus,
	output logic [`GM_MEM_ADDR_WIDTH-1:0] ram_addr,
	output gm_pkg::data_t ram_wr_data,
	output gm_pkg::strb_t ram_wbe,
	input gm_pkg::data_t ram_rd_data
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WRITE = 2'd1;
	localparam logic [1:0] ST_READ = 2'd2;

	logic [1:0] state;
	logic [`GM_MEM_ADDR_WIDTH-1:0] addr_q;
	gm_pkg::block_t beats;
	logic rd_valid_q;
	logic wr_beat;
	logic rd_beat;
	logic last_beat;

	assign wr_beat = (state == ST_WRITE) && bus.wr_valid;
	assign rd_beat = rd_valid_q && bus.rd_accept;
	assign last_beat = (beats == '0);

	// ----------------------------------------
	// DTL side
	assign bus.cmd_accept = (state == ST_IDLE);
	assign bus.wr_accept = (state == ST_WRITE);
	assign bus.rd_valid = rd_valid_q;
	assign bus.rd_last = rd_valid_q && last_beat;
	assign bus.rd_data = ram_rd_data;

	// ----------------------------------------
	// RAM side
	// look one word ahead when a read beat is taken, otherwise hold
	// the address so the registered output stays put
	assign ram_addr = rd_beat ? addr_q + 1'b1 : addr_q;
	assign ram_wr_data = bus.wr_data;
	assign ram_wbe = wr_beat ? bus.wr_mask : '0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			rd_valid_q <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (bus.cmd_valid)
						state <= bus.cmd_read ? ST_READ : ST_WRITE;
				end
				ST_WRITE:
				begin
					if (wr_beat && last_beat)
						state <= ST_IDLE;
				end
				ST_READ:
				begin
					if (rd_beat && last_beat)
					begin
						state <= ST_IDLE;
						rd_valid_q <= 1'b0;
					end
					else
					begin
						rd_valid_q <= 1'b1;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// word address and beat count, loaded with the command
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && bus.cmd_valid)
		begin
			addr_q <= bus.addr.fields.word;
			beats <= bus.block_size;
		end
		else if (wr_beat || rd_beat)
		begin
			addr_q <= addr_q + 1'b1;
			beats <= beats - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/gm_defines.svh ====
`ifndef GM_DEFINES_SVH
`define GM_DEFINES_SVH

// data path
`define GM_DATA_WIDTH 32
`define GM_NUM_ENABLES 4

// DTL command fields
`define GM_ADDR_WIDTH 32
`define GM_BLOCK_WIDTH 5

// global memory, 8192 words
`define GM_MEM_ADDR_WIDTH 13

// highest byte address answered by the memory
`define GM_RANGE_HIGH 32767

// arbiter ports, host and core
`define GM_NUM_PORTS 2

`endif

// ==== logic/gm_pkg.sv ====
`include "gm_defines.svh"
`default_nettype none

package gm_pkg;

	typedef logic [`GM_DATA_WIDTH-1:0] data_t;
	typedef logic [`GM_NUM_ENABLES-1:0] strb_t;

	// number of beats minus one
	typedef logic [`GM_BLOCK_WIDTH-1:0] block_t;

	localparam int OFFSET_WIDTH = $clog2(`GM_NUM_ENABLES);
	localparam int UPPER_WIDTH = `GM_ADDR_WIDTH - `GM_MEM_ADDR_WIDTH - OFFSET_WIDTH;

	typedef struct packed {
		logic [UPPER_WIDTH-1:0] upper;
		logic [`GM_MEM_ADDR_WIDTH-1:0] word;
		logic [OFFSET_WIDTH-1:0] offset;
	} dtl_addr_fields_t;

	// byte address, flat for range checks or split into word index
	typedef union packed {
		logic [`GM_ADDR_WIDTH-1:0] flat;
		dtl_addr_fields_t fields;
	} dtl_addr_u;

endpackage

`default_nettype wire

// ==== logic/gm_subsystem.sv ====
`timescale 1ns/1ps
`include "gm_defines.svh"
`default_nettype none

module gm_subsystem (
	input logic clk,
	input logic rst,

	// host port
	input logic host_cmd_valid,
	input logic host_cmd_read,
	input logic [`GM_ADDR_WIDTH-1:0] host_addr,
	input logic [`GM_BLOCK_WIDTH-1:0] host_block_size,
	input logic host_wr_valid,
	input logic host_wr_last,
	input logic [`GM_NUM_ENABLES-1:0] host_wr_mask,
	input logic [`GM_DATA_WIDTH-1:0] host_wr_data,
	input logic host_rd_accept,
	output logic host_cmd_accept,
	output logic host_wr_accept,
	output logic host_rd_valid,
	output logic host_rd_last,
	output logic [`GM_DATA_WIDTH-1:0] host_rd_data,

	// core port
	input logic core_cmd_valid,
	input logic core_cmd_read,
	input logic [`GM_ADDR_WIDTH-1:0] core_addr,
	input logic [`GM_BLOCK_WIDTH-1:0] core_block_size,
	input logic core_wr_valid,
	input logic core_wr_last,
	input logic [`GM_NUM_ENABLES-1:0] core_wr_mask,
	input logic [`GM_DATA_WIDTH-1:0] core_wr_data,
	input logic core_rd_accept,
	output logic core_cmd_accept,
	output logic core_wr_accept,
	output logic core_rd_valid,
	output logic core_rd_last,
	output logic [`GM_DATA_WIDTH-1:0] core_rd_data
);

	dtl_if host_bus ();
	dtl_if core_bus ();
	dtl_if arb_bus ();
	dtl_if mem_bus ();

	logic [`GM_MEM_ADDR_WIDTH-1:0] ram_addr;
	gm_pkg::data_t ram_wr_data;
	gm_pkg::strb_t ram_wbe;
	gm_pkg::data_t ram_rd_data;

	// ----------------------------------------
	// plain ports onto the bus interfaces
	assign host_bus.cmd_valid = host_cmd_valid;
	assign host_bus.cmd_read = host_cmd_read;
	assign host_bus.addr = host_addr;
	assign host_bus.block_size = host_block_size;
	assign host_bus.wr_valid = host_wr_valid;
	assign host_bus.wr_last = host_wr_last;
	assign host_bus.wr_mask = host_wr_mask;
	assign host_bus.wr_data = host_wr_data;
	assign host_bus.rd_accept = host_rd_accept;
	assign host_cmd_accept = host_bus.cmd_accept;
	assign host_wr_accept = host_bus.wr_accept;
	assign host_rd_valid = host_bus.rd_valid;
	assign host_rd_last = host_bus.rd_last;
	assign host_rd_data = host_bus.rd_data;

	assign core_bus.cmd_valid = core_cmd_valid;
	assign core_bus.cmd_read = core_cmd_read;
	assign core_bus.addr = core_addr;
	assign core_bus.block_size = core_block_size;
	assign core_bus.wr_valid = core_wr_valid;
	assign core_bus.wr_last = core_wr_last;
	assign core_bus.wr_mask = core_wr_mask;
	assign core_bus.wr_data = core_wr_data;
	assign core_bus.rd_accept = core_rd_accept;
	assign core_cmd_accept = core_bus.cmd_accept;
	assign core_wr_accept = core_bus.wr_accept;
	assign core_rd_valid = core_bus.rd_valid;
	assign core_rd_last = core_bus.rd_last;
	assign core_rd_data = core_bus.rd_data;

	// ----------------------------------------
	// arbiter, isolator, controller, memory
	dtl_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.host(host_bus.slave),
		.core(core_bus.slave),
		.out(arb_bus.master)
	);

	dtl_address_isolator u_isolator (
		.clk(clk),
		.rst(rst),
		.up(arb_bus.slave),
		.down(mem_bus.master)
	);

	dtl_sram_controller u_controller (
		.clk(clk),
		.rst(rst),
		.bus(mem_bus.slave),
		.ram_addr(ram_addr),
		.ram_wr_data(ram_wr_data),
		.ram_wbe(ram_wbe),
		.ram_rd_data(ram_rd_data)
	);

	// one address drives both RAM ports
	ram_sdp_be u_ram (
		.clk(clk),
		.wr_addr(ram_addr),
		.rd_addr(ram_addr),
		.wr_data(ram_wr_data),
		.wbe(ram_wbe),
		.rd_data(ram_rd_data)
	);

endmodule

`default_nettype wire

// ==== logic/ram_sdp_be.sv ====
`timescale 1ns/1ps
`include "gm_defines.svh"
`default_nettype none

module ram_sdp_be (
	input logic clk,
	input logic [`GM_MEM_ADDR_WIDTH-1:0] wr_addr,
	input logic [`GM_MEM_ADDR_WIDTH-1:0] rd_addr,
	input gm_pkg::data_t wr_data,
	input gm_pkg::strb_t wbe,
	output gm_pkg::data_t rd_data
);

	localparam int LANE_W = `GM_DATA_WIDTH / `GM_NUM_ENABLES;
	localparam int DEPTH = 1 << `GM_MEM_ADDR_WIDTH;

	gm_pkg::data_t mem [0:DEPTH-1];

	// one enable per byte lane, read is registered
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < `GM_NUM_ENABLES; b++)
		begin
			if (wbe[b])
				mem[wr_addr][b*LANE_W +: LANE_W] <= wr_data[b*LANE_W +: LANE_W];
		end
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the global memory testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module gm_subsystem_tb \
	-f vlog.f -o gm_sim &&
./obj_dir/gm_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation PASSED" ||
{ echo "simulation FAILED"; exit 1; }

// ==== sim/gm_checker.sv ====
`timescale 1ns/1ps
`include "gm_defines.svh"
`default_nettype none

module gm_checker (
	input logic clk,
	input logic rst,
	input logic [`GM_NUM_PORTS-1:0] cmd_valid,
	input logic [`GM_NUM_PORTS-1:0] cmd_accept,
	input logic [`GM_NUM_PORTS-1:0] cmd_read,
	input logic [`GM_NUM_PORTS-1:0][`GM_ADDR_WIDTH-1:0] addr,
	input logic [`GM_NUM_PORTS-1:0][`GM_BLOCK_WIDTH-1:0] block_size,
	input logic [`GM_NUM_PORTS-1:0] wr_valid,
	input logic [`GM_NUM_PORTS-1:0] wr_accept,
	input logic [`GM_NUM_PORTS-1:0][`GM_NUM_ENABLES-1:0] wr_mask,
	input logic [`GM_NUM_PORTS-1:0][`GM_DATA_WIDTH-1:0] wr_data,
	input logic [`GM_NUM_PORTS-1:0] rd_valid,
	input logic [`GM_NUM_PORTS-1:0] rd_accept,
	input logic [`GM_NUM_PORTS-1:0] rd_last,
	input logic [`GM_NUM_PORTS-1:0][`GM_DATA_WIDTH-1:0] rd_data,
	output int value_errors,
	output int protocol_errors,
	output int reads_checked
);

	// byte model of the memory
	logic [7:0] model [0:`GM_RANGE_HIGH];

	// ----------------------------------------
	// transfer in flight per port
	logic [`GM_NUM_PORTS-1:0] active;
	logic [`GM_NUM_PORTS-1:0] is_read;
	logic [`GM_NUM_PORTS-1:0][`GM_ADDR_WIDTH-1:0] base;
	logic [`GM_NUM_PORTS-1:0][`GM_BLOCK_WIDTH-1:0] final_beat;
	int beat [`GM_NUM_PORTS];
	logic [`GM_NUM_PORTS-1:0] held;
	logic [`GM_NUM_PORTS-1:0] held_last;
	logic [`GM_NUM_PORTS-1:0][`GM_DATA_WIDTH-1:0] held_data;

	function automatic string port_name(input int p);
		return (p == 0) ? "host" : "core";
	endfunction

	// zero outside the memory range
	function automatic logic [`GM_DATA_WIDTH-1:0] expected_word(input logic [31:0] a);
		logic [`GM_DATA_WIDTH-1:0] w;
		w = '0;
		if (a <= `GM_ADDR_WIDTH'(`GM_RANGE_HIGH))
		begin
			for (int b = 0; b < `GM_NUM_ENABLES; b++)
				w[b*8 +: 8] = model[a + b];
		end
		return w;
	endfunction

	always @(posedge clk)
	begin
		logic [`GM_ADDR_WIDTH-1:0] beat_addr;
		logic [`GM_DATA_WIDTH-1:0] expected;
		logic expected_last;
		if (rst)
		begin
			active = '0;
			held = '0;
			value_errors = 0;
			protocol_errors = 0;
			reads_checked = 0;
		end
		else
		begin
			for (int p = 0; p < `GM_NUM_PORTS; p++)
			begin
				beat_addr = base[p] + (`GM_ADDR_WIDTH'(beat[p]) << 2);
				if (held[p] && rd_data[p] !== held_data[p])
				begin
					$display("[FAIL] %0t %s_rd_data expected %h got %h (stalled beat)",
						$time, port_name(p), held_data[p], rd_data[p]);
					value_errors++;
				end
				if (held[p] && rd_last[p] !== held_last[p])
				begin
					$display("[FAIL] %0t %s_rd_last expected %b got %b (stalled beat)",
						$time, port_name(p), held_last[p], rd_last[p]);
					value_errors++;
				end
				if (rd_last[p] && !rd_valid[p])
				begin
					$display("%0t %s rd_last is high without rd_valid", $time, port_name(p));
					protocol_errors++;
				end
				if (cmd_valid[p] && cmd_accept[p])
				begin
					if (active[p] || active[1-p])
					begin
						$display("%0t %s command accepted while a transfer is still open",
							$time, port_name(p));
						protocol_errors++;
					end
					active[p] = 1'b1;
					is_read[p] = cmd_read[p];
					base[p] = addr[p];
					final_beat[p] = block_size[p];
					beat[p] = 0;
				end
				else if (active[p] && !is_read[p] && wr_valid[p] && wr_accept[p])
				begin
					if (beat_addr <= `GM_ADDR_WIDTH'(`GM_RANGE_HIGH))
					begin
						for (int b = 0; b < `GM_NUM_ENABLES; b++)
							if (wr_mask[p][b])
								model[beat_addr + b] = wr_data[p][b*8 +: 8];
					end
					if (beat[p] == int'(final_beat[p]))
						active[p] = 1'b0;
					beat[p]++;
				end
				// the port without an open read must see rd_valid low
				if (rd_valid[p] && (!active[p] || !is_read[p]))
				begin
					$display("%0t %s rd_valid is high outside a read transfer",
						$time, port_name(p));
					protocol_errors++;
				end
				else if (rd_valid[p] && rd_accept[p])
				begin
					expected = expected_word(beat_addr);
					expected_last = (beat[p] == int'(final_beat[p]));
					if (rd_data[p] !== expected)
					begin
						$display("[FAIL] %0t %s_rd_data expected %h got %h",
							$time, port_name(p), expected, rd_data[p]);
						value_errors++;
					end
					if (rd_last[p] !== expected_last)
					begin
						$display("[FAIL] %0t %s_rd_last expected %b got %b",
							$time, port_name(p), expected_last, rd_last[p]);
						value_errors++;
					end
					reads_checked++;
					if (expected_last)
						active[p] = 1'b0;
					beat[p]++;
				end
				held[p] = rd_valid[p] && !rd_accept[p];
				held_data[p] = rd_data[p];
				held_last[p] = rd_last[p];
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/gm_subsystem_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module gm_subsystem_sva (
	input logic clk,
	input logic rst,
	input logic host_cmd_accept,
	input logic host_rd_valid,
	input logic host_rd_accept,
	input logic host_rd_last,
	input logic [31:0] host_rd_data,
	input logic core_cmd_accept,
	input logic core_rd_valid,
	input logic core_rd_accept,
	input logic core_rd_last,
	input logic [31:0] core_rd_data
);

	a_host_last_valid: assert property (@(posedge clk) disable iff (rst)
		host_rd_last |-> host_rd_valid)
		else $error("host rd_last high without rd_valid");

	a_core_last_valid: assert property (@(posedge clk) disable iff (rst)
		core_rd_last |-> core_rd_valid)
		else $error("core rd_last high without rd_valid");

	// only one port can win the shared memory at a time
	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		!(host_cmd_accept && core_cmd_accept))
		else $error("host and core commands accepted together");

	a_host_hold: assert property (@(posedge clk) disable iff (rst)
		host_rd_valid && !host_rd_accept |=> $stable(host_rd_data) && $stable(host_rd_last))
		else $error("host read beat changed while stalled");

	a_core_hold: assert property (@(posedge clk) disable iff (rst)
		core_rd_valid && !core_rd_accept |=> $stable(core_rd_data) && $stable(core_rd_last))
		else $error("core read beat changed while stalled");

endmodule

bind gm_subsystem gm_subsystem_sva u_sva (
	.clk(clk),
	.rst(rst),
	.host_cmd_accept(host_cmd_accept),
	.host_rd_valid(host_rd_valid),
	.host_rd_accept(host_rd_accept),
	.host_rd_last(host_rd_last),
	.host_rd_data(host_rd_data),
	.core_cmd_accept(core_cmd_accept),
	.core_rd_valid(core_rd_valid),
	.core_rd_accept(core_rd_accept),
	.core_rd_last(core_rd_last),
	.core_rd_data(core_rd_data)
);

`default_nettype wire

// ==== sim/gm_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "gm_defines.svh"
`default_nettype none

module gm_subsystem_tb;

	localparam int NP = `GM_NUM_PORTS;
	localparam int NUM_ROWS = 16;
	localparam logic HOST = 1'b0;
	localparam logic CORE = 1'b1;
	localparam logic WR = 1'b0;
	localparam logic RD = 1'b1;

	typedef struct packed {
		logic port;
		logic read;
		logic [`GM_ADDR_WIDTH-1:0] addr;
		gm_pkg::block_t block_size;
		gm_pkg::strb_t mask;
		logic stall;
		logic with_next;
	} row_t;

	logic clk = 1'b0;
	logic rst;
	logic [NP-1:0] cmd_valid;
	logic [NP-1:0] cmd_read;
	logic [NP-1:0][`GM_ADDR_WIDTH-1:0] addr;
	logic [NP-1:0][`GM_BLOCK_WIDTH-1:0] block_size;
	logic [NP-1:0] wr_valid;
	logic [NP-1:0] wr_last;
	logic [NP-1:0][`GM_NUM_ENABLES-1:0] wr_mask;
	logic [NP-1:0][`GM_DATA_WIDTH-1:0] wr_data;
	logic [NP-1:0] rd_accept;
	wire [NP-1:0] cmd_accept;
	wire [NP-1:0] wr_accept;
	wire [NP-1:0] rd_valid;
	wire [NP-1:0] rd_last;
	wire [NP-1:0][`GM_DATA_WIDTH-1:0] rd_data;

	row_t rows [NUM_ROWS];
	int cycles = 0;
	int limit = 0;
	int expected_reads;
	int shortfall = 0;
	int value_errors;
	int protocol_errors;
	int reads_checked;

	always #10 clk = ~clk;

	gm_subsystem u_dut (
		.clk(clk), .rst(rst),
		.host_cmd_valid(cmd_valid[0]), .host_cmd_read(cmd_read[0]),
		.host_addr(addr[0]), .host_block_size(block_size[0]),
		.host_wr_valid(wr_valid[0]), .host_wr_last(wr_last[0]),
		.host_wr_mask(wr_mask[0]), .host_wr_data(wr_data[0]),
		.host_rd_accept(rd_accept[0]), .host_cmd_accept(cmd_accept[0]),
		.host_wr_accept(wr_accept[0]), .host_rd_valid(rd_valid[0]),
		.host_rd_last(rd_last[0]), .host_rd_data(rd_data[0]),
		.core_cmd_valid(cmd_valid[1]), .core_cmd_read(cmd_read[1]),
		.core_addr(addr[1]), .core_block_size(block_size[1]),
		.core_wr_valid(wr_valid[1]), .core_wr_last(wr_last[1]),
		.core_wr_mask(wr_mask[1]), .core_wr_data(wr_data[1]),
		.core_rd_accept(rd_accept[1]), .core_cmd_accept(cmd_accept[1]),
		.core_wr_accept(wr_accept[1]), .core_rd_valid(rd_valid[1]),
		.core_rd_last(rd_last[1]), .core_rd_data(rd_data[1])
	);

	gm_checker u_checker (
		.clk(clk), .rst(rst),
		.cmd_valid(cmd_valid), .cmd_accept(cmd_accept), .cmd_read(cmd_read),
		.addr(addr), .block_size(block_size),
		.wr_valid(wr_valid), .wr_accept(wr_accept), .wr_mask(wr_mask), .wr_data(wr_data),
		.rd_valid(rd_valid), .rd_accept(rd_accept), .rd_last(rd_last), .rd_data(rd_data),
		.value_errors(value_errors), .protocol_errors(protocol_errors),
		.reads_checked(reads_checked)
	);

	task automatic load_table();
		// port, read, byte address, block size, mask, stalled, starts with next row
		rows[0] = '{HOST, WR, 32'h0000_0100, 5'd0, 4'hf, 1'b0, 1'b0};
		rows[1] = '{HOST, RD, 32'h0000_0100, 5'd0, 4'hf, 1'b0, 1'b0};
		rows[2] = '{HOST, WR, 32'h0000_0100, 5'd0, 4'b0101, 1'b0, 1'b0};
		rows[3] = '{HOST, RD, 32'h0000_0100, 5'd0, 4'hf, 1'b0, 1'b0};
		rows[4] = '{CORE, WR, 32'h0000_2000, 5'd7, 4'hf, 1'b0, 1'b0};
		rows[5] = '{CORE, RD, 32'h0000_2000, 5'd7, 4'hf, 1'b0, 1'b0};
		// word 0 and then the address just past the memory
		rows[6] = '{HOST, WR, 32'h0000_0000, 5'd0, 4'hf, 1'b0, 1'b0};
		rows[7] = '{HOST, WR, 32'h0000_8000, 5'd3, 4'hf, 1'b0, 1'b0};
		rows[8] = '{HOST, RD, 32'h0000_0000, 5'd0, 4'hf, 1'b0, 1'b0};
		rows[9] = '{CORE, RD, 32'h0000_8000, 5'd3, 4'hf, 1'b0, 1'b0};
		// both ports at once
		rows[10] = '{HOST, WR, 32'h0000_0400, 5'd3, 4'hf, 1'b0, 1'b1};
		rows[11] = '{CORE, WR, 32'h0000_0600, 5'd3, 4'hf, 1'b0, 1'b0};
		rows[12] = '{HOST, RD, 32'h0000_0400, 5'd3, 4'hf, 1'b0, 1'b1};
		rows[13] = '{CORE, RD, 32'h0000_0600, 5'd3, 4'hf, 1'b0, 1'b0};
		rows[14] = '{CORE, RD, 32'h0000_2000, 5'd7, 4'hf, 1'b1, 1'b0};
		rows[15] = '{HOST, RD, 32'h0000_2000, 5'd7, 4'hf, 1'b1, 1'b0};
	endtask

	function automatic int count_beats(input logic reads_only);
		int total;
		total = 0;
		for (int i = 0; i < NUM_ROWS; i++)
			if (!reads_only || rows[i].read)
				total += int'(rows[i].block_size) + 1;
		return total;
	endfunction

	// one whole transfer on one port starting right after a rising edge
	task automatic run_transfer(input row_t r);
		int beats;
		cmd_valid[r.port] <= 1'b1;
		cmd_read[r.port] <= r.read;
		addr[r.port] <= r.addr;
		block_size[r.port] <= r.block_size;
		@(posedge clk);
		while (!cmd_accept[r.port])
			@(posedge clk);
		cmd_valid[r.port] <= 1'b0;
		if (!r.read)
		begin
			for (beats = 0; beats <= int'(r.block_size); beats++)
			begin
				wr_valid[r.port] <= 1'b1;
				wr_last[r.port] <= (beats == int'(r.block_size));
				wr_mask[r.port] <= r.mask;
				wr_data[r.port] <= $urandom;
				@(posedge clk);
				while (!wr_accept[r.port])
					@(posedge clk);
			end
			wr_valid[r.port] <= 1'b0;
			wr_last[r.port] <= 1'b0;
		end
		else
		begin
			beats = 0;
			while (beats <= int'(r.block_size))
			begin
				rd_accept[r.port] <= r.stall ? 1'($urandom) : 1'b1;
				@(posedge clk);
				if (rd_valid[r.port] && rd_accept[r.port])
					beats++;
			end
			rd_accept[r.port] <= 1'b0;
		end
	endtask

	task automatic report_counts();
		$display("value errors %0d, protocol errors %0d, missing reads %0d, reads checked %0d",
			value_errors, protocol_errors, shortfall, reads_checked);
	endtask

	// ----------------------------------------
	// run the table
	initial
	begin
		int idx;
		void'($urandom(14818));
		rst = 1'b1;
		cmd_valid = '0;
		cmd_read = '0;
		addr = '0;
		block_size = '0;
		wr_valid = '0;
		wr_last = '0;
		wr_mask = '0;
		wr_data = '0;
		rd_accept = '0;
		load_table();
		limit = 200 + 8 * count_beats(1'b0);
		expected_reads = count_beats(1'b1);
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		idx = 0;
		while (idx < NUM_ROWS)
		begin
			@(posedge clk);
			if (rows[idx].with_next && idx + 1 < NUM_ROWS)
			begin
				fork
					run_transfer(rows[idx]);
					run_transfer(rows[idx + 1]);
				join
				idx += 2;
			end
			else
			begin
				run_transfer(rows[idx]);
				idx++;
			end
		end
		repeat (4) @(posedge clk);
		if (reads_checked != expected_reads)
		begin
			$display("checker saw %0d read beats, the table asks for %0d",
				reads_checked, expected_reads);
			shortfall = expected_reads - reads_checked;
		end
		report_counts();
		if (value_errors == 0 && protocol_errors == 0 && shortfall == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("timeout after %0d cycles, transfers did not complete", cycles);
			report_counts();
			$display("Test failures found");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/gm_pkg.sv
logic/dtl_if.sv
logic/dtl_arbiter.sv
logic/dtl_address_isolator.sv
logic/dtl_sram_controller.sv
logic/ram_sdp_be.sv
logic/gm_subsystem.sv
sim/gm_subsystem_sva.sv
sim/gm_checker.sv
sim/gm_subsystem_tb.sv
